// File: include/ai_pool_params.svh
`ifndef AI_POOL_PARAMS_SVH
`define AI_POOL_PARAMS_SVH

////////////////////////////////////////
// feature map geometry
////////////////////////////////////////

// rows per frame, must be even for 2x2 pooling
`define AI_MAP_H 8

// pixels per row, must be even
`define AI_MAP_W 8

////////////////////////////////////////
// pixel format
////////////////////////////////////////

`define AI_PIX_W 8  // unsigned pixel bits

`endif

// File: src/ai_pool_pkg.sv
`default_nettype none

`include "ai_pool_params.svh"

package ai_pool_pkg;

    ////////////////////////////////////////
    // data types
    ////////////////////////////////////////

    typedef logic [`AI_PIX_W-1:0] pixel_t;     // one unsigned pixel
    typedef pixel_t [`AI_MAP_W-1:0] row_t;     // full row, pixel 0 in low bits

    // indices into the map
    typedef logic [$clog2(`AI_MAP_H)-1:0] row_inx_t;
    typedef logic [$clog2(`AI_MAP_W)-1:0] col_inx_t;

    typedef logic [1:0] cmp_cnt_t;             // compare step, 0..2

    ////////////////////////////////////////
    // pooling FSM
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        st_idle,     // waiting for a full frame
        st_load,     // latch the four window pixels
        st_compare,  // three serial compares
        st_emit      // present the window max
    } pool_state_t;

endpackage

`default_nettype wire

// File: src/ai_win_if.sv
`timescale 1ns/1ns
`default_nettype none

// window port between the frame buffer and the pooling FSM
interface ai_win_if;
    import ai_pool_pkg::*;

    ////////////////////////////////////////
    // frame status
    ////////////////////////////////////////

    logic frame_valid;     // full frame held in the buffer
    logic frame_release;   // one-cycle pulse, frees the buffer

    ////////////////////////////////////////
    // window request and data
    ////////////////////////////////////////

    // top-left corner of the window, always even
    row_inx_t win_row;
    col_inx_t win_col;

    // 0 top-left, 1 top-right, 2 bottom-left, 3 bottom-right
    pixel_t [3:0] win_pix;

    // buffer side serves pixels for the requested corner
    modport buffer (
        output frame_valid,
        output win_pix,
        input  win_row,
        input  win_col,
        input  frame_release
    );

    // pool side walks corners and releases the frame when done
    modport pool (
        input  frame_valid,
        input  win_pix,
        output win_row,
        output win_col,
        output frame_release
    );

endinterface

`default_nettype wire

// File: src/ai_map_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "ai_pool_params.svh"

module ai_map_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              row_valid,
    input  ai_pool_pkg::row_t row_data,
    output logic              busy,
    ai_win_if.buffer          win
);
    import ai_pool_pkg::*;

    ////////////////////////////////////////
    // storage and control state
    ////////////////////////////////////////

    row_t     frame_mem [0:`AI_MAP_H-1];  // one entry per map row
    row_inx_t row_cnt;                    // next row to write
    logic     full_q;                     // frame complete, held for pooling

    logic     row_accept;
    logic     last_row;

    // bottom row and right column of the window
    row_inx_t row_b;
    col_inx_t col_r;

    ////////////////////////////////////////
    // row intake
    ////////////////////////////////////////

    // rows strobed while the frame is held are simply dropped
    assign row_accept = row_valid && !full_q;
    assign last_row   = (row_cnt == row_inx_t'(`AI_MAP_H - 1));

    // frame storage, written one row per accepted strobe
    always_ff @(posedge clk) begin
        if (row_accept) begin
            frame_mem[row_cnt] <= row_data;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            row_cnt <= '0;
            full_q  <= 1'b0;
        end else if (win.frame_release) begin
            // pool finished, open for the next frame
            row_cnt <= '0;
            full_q  <= 1'b0;
        end else if (row_accept) begin
            if (last_row) begin
                row_cnt <= '0;
                full_q  <= 1'b1;  // busy from the next cycle on
            end else begin
                row_cnt <= row_cnt + row_inx_t'(1);
            end
        end
    end

    // busy and frame_valid track the same flag
    assign busy            = full_q;
    assign win.frame_valid = full_q;

    ////////////////////////////////////////
    // window read
    ////////////////////////////////////////

    // corner is even, so the neighbour is always inside the map
    assign row_b = win.win_row + row_inx_t'(1);
    assign col_r = win.win_col + col_inx_t'(1);

    // purely combinational, follows the corner in the same cycle
    always_comb begin
        win.win_pix[0] = frame_mem[win.win_row][win.win_col];  // top-left
        win.win_pix[1] = frame_mem[win.win_row][col_r];        // top-right
        win.win_pix[2] = frame_mem[row_b][win.win_col];        // bottom-left
        win.win_pix[3] = frame_mem[row_b][col_r];              // bottom-right
    end

endmodule

`default_nettype wire

// File: src/ai_pool.sv
`timescale 1ns/1ns
`default_nettype none

`include "ai_pool_params.svh"

module ai_pool (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pool_en,
    ai_win_if.pool                win,
    output logic                  res_valid,
    output ai_pool_pkg::pixel_t   res_data,
    output ai_pool_pkg::row_inx_t res_row,
    output ai_pool_pkg::col_inx_t res_col,
    output logic                  done
);
    import ai_pool_pkg::*;

    ////////////////////////////////////////
    // state
    ////////////////////////////////////////

    pool_state_t state;
    row_inx_t    win_row;   // even corner of the current window
    col_inx_t    win_col;
    cmp_cnt_t    cmp_cnt;   // which compare of three
    cmp_cnt_t    cmp_idx;   // pixel taken in this compare
    logic        done_q;

    // window payload, top-left goes straight into max_q
    pixel_t      pix_q [1:3];
    pixel_t      max_q;     // running maximum

    logic        last_col;
    logic        last_win;

    assign last_col = (win_col == col_inx_t'(`AI_MAP_W - 2));
    assign last_win = last_col && (win_row == row_inx_t'(`AI_MAP_H - 2));

    // compare n looks at pixel n+1
    assign cmp_idx = cmp_cnt + cmp_cnt_t'(1);

    ////////////////////////////////////////
    // window sequencer
    ////////////////////////////////////////

    // everything holds while pool_en is low
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            win_row <= '0;
            win_col <= '0;
            cmp_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;  // single-cycle pulse
            if (pool_en) begin
                case (state)
                    st_idle: begin
                        // done_q still high means this frame is being released
                        if (win.frame_valid && !done_q) begin
                            win_row <= '0;
                            win_col <= '0;
                            state   <= st_load;
                        end
                    end
                    st_load: begin
                        cmp_cnt <= '0;
                        state   <= st_compare;
                    end
                    st_compare: begin
                        if (cmp_cnt == cmp_cnt_t'(2)) begin
                            state <= st_emit;
                        end else begin
                            cmp_cnt <= cmp_cnt + cmp_cnt_t'(1);
                        end
                    end
                    st_emit: begin
                        if (last_win) begin
                            // last window emitted so rewind the corner
                            win_row <= '0;
                            win_col <= '0;
                            done_q  <= 1'b1;
                            state   <= st_idle;
                        end else begin
                            if (last_col) begin
                                win_col <= '0;  // next window row
                                win_row <= win_row + row_inx_t'(2);
                            end else begin
                                win_col <= win_col + col_inx_t'(2);
                            end
                            state <= st_load;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // max datapath
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pool_en) begin
            if (state == st_load) begin
                pix_q[1] <= win.win_pix[1];
                pix_q[2] <= win.win_pix[2];
                pix_q[3] <= win.win_pix[3];
                max_q    <= win.win_pix[0];  // top-left seeds the max
            end else if (state == st_compare) begin
                // ties keep the earlier pixel
                if (pix_q[cmp_idx] > max_q) begin
                    max_q <= pix_q[cmp_idx];
                end
            end
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    assign win.win_row       = win_row;
    assign win.win_col       = win_col;
    assign win.frame_release = done_q;  // same cycle as done

    assign res_valid = (state == st_emit) && pool_en;  // no pulse while frozen
    assign res_data  = max_q;
    assign res_row   = win_row >> 1;    // pooled coordinates
    assign res_col   = win_col >> 1;
    assign done      = done_q;

endmodule

`default_nettype wire

// File: src/ai_pool_top.sv
`timescale 1ns/1ns
`default_nettype none

module ai_pool_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  row_valid,
    input  ai_pool_pkg::row_t     row_data,
    input  logic                  pool_en,
    output logic                  busy,
    output logic                  res_valid,
    output ai_pool_pkg::pixel_t   res_data,
    output ai_pool_pkg::row_inx_t res_row,
    output ai_pool_pkg::col_inx_t res_col,
    output logic                  done
);

    ////////////////////////////////////////
    // buffer to pool window link
    ////////////////////////////////////////

    ai_win_if win_bus ();

    ////////////////////////////////////////
    // frame buffer
    ////////////////////////////////////////

    // collects rows, holds the frame while pooling runs
    ai_map_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .row_valid (row_valid),
        .row_data  (row_data),
        .busy      (busy),
        .win       (win_bus.buffer)
    );

    ////////////////////////////////////////
    // pooling FSM
    ////////////////////////////////////////

    ai_pool u_pool (
        .clk       (clk),
        .rst       (rst),
        .pool_en   (pool_en),
        .win       (win_bus.pool),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_row   (res_row),
        .res_col   (res_col),
        .done      (done)   // also frees the buffer
    );

endmodule

`default_nettype wire

// File: tests/ai_pool_chk.sv
`timescale 1ns/1ns
`default_nettype none

module ai_pool_chk (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic res_valid,
    input logic done
);

    ////////////////////////////////////////
    // result and done strobes
    ////////////////////////////////////////

    res_done_excl: assert property (@(posedge clk) disable iff (rst) !(res_valid && done))
        else $error("res_valid and done high in the same cycle");

    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held longer than one cycle");

    // results only while a frame is held
    res_in_frame: assert property (@(posedge clk) disable iff (rst) $rose(res_valid) |-> busy)
        else $error("res_valid rose with busy low");

    ////////////////////////////////////////
    // busy window
    ////////////////////////////////////////

    busy_at_done: assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else $error("busy low during done");

    busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(done))
        else $error("busy fell without a done the cycle before");

    busy_release: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
        else $error("busy still high the cycle after done");

endmodule

bind ai_pool_top ai_pool_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .busy      (busy),
    .res_valid (res_valid),
    .done      (done)
);

`default_nettype wire

// File: tests/ai_pool_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "ai_pool_params.svh"

module ai_pool_tb;
    import ai_pool_pkg::*;

    localparam int H    = `AI_MAP_H;
    localparam int W    = `AI_MAP_W;
    localparam int PW   = W / 2;               // pooled row width
    localparam int NRES = (H / 2) * PW;
    localparam int TMO  = 4000;                // cycles allowed per wait

    logic     clk;
    logic     rst;
    logic     row_valid;
    logic     pool_en;
    row_t     row_data;
    logic     busy;
    logic     res_valid;
    logic     done;
    pixel_t   res_data;
    row_inx_t res_row;
    col_inx_t res_col;

    integer seed = 32'h8bf1_dbef;
    int     cycle = 0;
    int     err_cnt = 0;
    int     test_cnt = 0;
    int     fail_cnt = 0;
    int     test_err0 = 0;
    int     clear_seq = 0;                     // bumped to empty the capture

    pixel_t frame [0:H-1][0:W-1];              // model copy of the loaded frame

    // written by the monitor only
    pixel_t got_data [$];
    int     got_row [$];
    int     got_col [$];
    int     got_cyc [$];
    int     seen_seq = 0;
    int     done_cnt = 0;
    int     done_cyc = -1;
    int     rise_cyc = -1;
    int     fall_cyc = -1;
    int     frozen_cnt = 0;                    // results seen with pool_en low
    logic   busy_q = 1'b0;

    ai_pool_top UUT (
        .clk       (clk),
        .rst       (rst),
        .row_valid (row_valid),
        .row_data  (row_data),
        .pool_en   (pool_en),
        .busy      (busy),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_row   (res_row),
        .res_col   (res_col),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////
    // output monitor sampling mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (clear_seq != seen_seq) begin
            seen_seq = clear_seq;
            got_data.delete();
            got_row.delete();
            got_col.delete();
            got_cyc.delete();
            done_cnt   = 0;
            frozen_cnt = 0;
            done_cyc   = -1;
            rise_cyc   = -1;
            fall_cyc   = -1;
        end
        if (res_valid) begin
            got_data.push_back(res_data);
            got_row.push_back(int'(res_row));
            got_col.push_back(int'(res_col));
            got_cyc.push_back(cycle);
        end
        if (res_valid && !pool_en) frozen_cnt = frozen_cnt + 1;
        if (done) begin
            done_cnt = done_cnt + 1;
            done_cyc = cycle;
        end
        if (busy && !busy_q) rise_cyc = cycle;  // frame_valid rises here too
        if (!busy && busy_q) fall_cyc = cycle;
        busy_q = busy;
    end

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////

    task automatic value_fail(input string name, input int got, input int exp);
        $display("[ERROR] t=%0t %s got %0d expected %0d", $time, name, got, exp);
        err_cnt = err_cnt + 1;
    endtask

    task automatic note_fail(input string what);
        $display("t=%0t %s", $time, what);
        err_cnt = err_cnt + 1;
    endtask

    task automatic abort_run(input string what);
        err_cnt = err_cnt + 1;
        $display("timeout: %s", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic clear_capture();
        clear_seq = clear_seq + 1;  // monitor empties at next negedge
    endtask

    task automatic start_test();
        clear_capture();
        test_err0 = err_cnt;
    endtask

    task automatic finish_test(input string name);
        test_cnt = test_cnt + 1;
        if (err_cnt == test_err0) begin
            $display("%-8s ok", name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("%-8s %0d error(s)", name, err_cnt - test_err0);
        end
    endtask

    ////////////////////////////////////////
    // stimulus and model
    ////////////////////////////////////////

    // 0 random, 1 all equal, 2 all max, 3 one max per block
    task automatic fill_frame(input int kind);
        pixel_t top;
        int     pos;
        top = '1;
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                pos = ((r / 2) * PW + c / 2) % 4;  // max position rotates per block
                case (kind)
                    0: frame[r][c] = pixel_t'($random(seed));
                    1: frame[r][c] = pixel_t'('h5a);
                    2: frame[r][c] = top;
                    default: frame[r][c] = ((r % 2) * 2 + c % 2 == pos) ? top
                                         : pixel_t'($random(seed)) >> 1;
                endcase
            end
        end
    endtask

    // max over the 2x2 block with the earliest pixel kept on a tie
    function automatic pixel_t block_max(input int br, input int bc);
        pixel_t m;
        m = frame[2 * br][2 * bc];
        for (int k = 1; k < 4; k++) begin
            if (frame[2 * br + k / 2][2 * bc + k % 2] > m) begin
                m = frame[2 * br + k / 2][2 * bc + k % 2];
            end
        end
        return m;
    endfunction

    // one row per clock while junk rows stay out of the model
    task automatic send_rows(input bit junk);
        row_t rd;
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                rd[c] = junk ? pixel_t'($random(seed)) : frame[r][c];
            end
            @(posedge clk);
            row_valid <= 1'b1;
            row_data  <= rd;
        end
        @(posedge clk);
        row_valid <= 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_cnt == 0 && n < TMO) begin
            @(posedge clk);
            n++;
        end
        if (done_cnt == 0) abort_run("no done pulse after the frame");
        n = 0;
        while (busy_q && n < TMO) begin
            @(posedge clk);
            n++;
        end
        if (busy_q) abort_run("busy stuck high after done");
    endtask

    task automatic check_results();
        int br;
        int bc;
        if (got_data.size() != NRES) value_fail("result count", got_data.size(), NRES);
        for (int i = 0; i < got_data.size() && i < NRES; i++) begin
            br = i / PW;  // raster order of blocks
            bc = i % PW;
            if (got_row[i] != br) value_fail("res_row", got_row[i], br);
            if (got_col[i] != bc) value_fail("res_col", got_col[i], bc);
            if (got_data[i] != block_max(br, bc)) begin
                value_fail("res_data", int'(got_data[i]), int'(block_max(br, bc)));
            end
        end
        if (done_cnt != 1) value_fail("done pulses", done_cnt, 1);
        if (frozen_cnt != 0) note_fail("res_valid pulsed while pool_en was low");
    endtask

    task automatic run_frame(input int kind);
        clear_capture();
        fill_frame(kind);
        pool_en <= 1'b1;
        send_rows(1'b0);
        wait_done();
        check_results();
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic raster_order();
        start_test();
        run_frame(0);
        finish_test("raster");
    endtask

    task automatic window_timing();
        start_test();
        run_frame(0);
        if (got_data.size() == NRES) begin
            if (got_cyc[0] - rise_cyc != 5) begin
                value_fail("first res delay", got_cyc[0] - rise_cyc, 5);
            end
            for (int i = 1; i < NRES; i++) begin
                if (got_cyc[i] - got_cyc[i - 1] != 5) begin
                    value_fail("res_valid spacing", got_cyc[i] - got_cyc[i - 1], 5);
                end
            end
            if (done_cyc - got_cyc[NRES - 1] != 1) begin
                value_fail("done delay", done_cyc - got_cyc[NRES - 1], 1);
            end
            if (fall_cyc - done_cyc != 1) value_fail("busy fall delay", fall_cyc - done_cyc, 1);
        end
        finish_test("timing");
    endtask

    task automatic busy_drop();
        start_test();
        fill_frame(0);
        pool_en <= 1'b0;  // hold the frame while junk arrives
        send_rows(1'b0);
        send_rows(1'b1);
        if (!busy_q) note_fail("busy low with a full frame held");
        pool_en <= 1'b1;
        wait_done();
        check_results();
        run_frame(0);     // fresh frame after release
        finish_test("drop");
    endtask

    task automatic pool_stall();
        pixel_t ref_data [$];
        int     n;
        int     r;
        start_test();
        run_frame(0);
        ref_data = got_data;
        clear_capture();
        send_rows(1'b0);  // same frame again
        n = 0;
        while (done_cnt == 0 && n < TMO) begin
            @(posedge clk);
            r = $random(seed);
            pool_en <= r[0];
            n++;
        end
        pool_en <= 1'b1;
        if (done_cnt == 0) abort_run("no done pulse with pool_en toggling");
        wait_done();
        check_results();
        for (int i = 0; i < got_data.size() && i < ref_data.size(); i++) begin
            if (got_data[i] != ref_data[i]) begin
                value_fail("res_data vs steady run", int'(got_data[i]), int'(ref_data[i]));
            end
        end
        finish_test("stall");
    endtask

    task automatic edge_frames();
        start_test();
        run_frame(1);
        run_frame(2);
        run_frame(3);
        finish_test("edges");
    endtask

    task automatic midpool_reset();
        int n;
        start_test();
        fill_frame(0);
        pool_en <= 1'b1;
        send_rows(1'b0);
        n = 0;
        while (got_data.size() < 2 && n < TMO) begin
            @(posedge clk);
            n++;
        end
        if (got_data.size() < 2) abort_run("no results before the reset");
        rst <= 1'b1;  // mid-pool
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        clear_capture();
        repeat (60) @(posedge clk);  // quiet window
        if (busy_q) note_fail("busy still high after reset");
        if (got_data.size() != 0) note_fail("result produced after reset");
        if (done_cnt != 0) note_fail("done pulsed after reset");
        run_frame(0);
        finish_test("reset");
    endtask

    initial begin
        rst       = 1'b1;
        row_valid = 1'b0;
        row_data  = '0;
        pool_en   = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        raster_order();
        window_timing();
        busy_drop();
        pool_stall();
        edge_frames();
        midpool_reset();
        repeat (4) @(posedge clk);
        $display("tests %0d, failing tests %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
src/ai_pool_pkg.sv
src/ai_win_if.sv
src/ai_map_buffer.sv
src/ai_pool.sv
src/ai_pool_top.sv
tests/ai_pool_chk.sv
tests/ai_pool_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the max-pool testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns -f sources.f \
    --top-module ai_pool_tb -o ai_pool_sim &&
./obj_dir/ai_pool_sim | tee /dev/stderr | grep "All checks passed" > /dev/null &&
echo "simulation ok" || { echo "simulation failed"; exit 1; }
